//--- bench/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb import isa_pkg::*, pipe_pkg::*; ();

  typedef struct packed {
    logic        pre;       // preload rs/rt through ws_wr
    logic [31:0] pre_rs;
    logic [31:0] pre_rt;
    logic [31:0] inst;
    logic [31:0] pc;
    fwd_src_t    es;
    fwd_src_t    ms;
    rf_write_t   ws;        // write-back report while decoding
    logic [3:0]  hold;      // cycles with es_allowin low
    logic [3:0]  stall;     // cycles the stage must stall
    logic        chk_dec;
    logic [4:0]  dest;
    alu_op_t     alu_op;
    src2_sel_t   src2_sel;
    logic        gr_we;
    logic        mem_we;
    logic        rsv;
    logic        load_op;
    logic        src1_is_sa;
    logic        src1_is_pc;
    logic        chk_ops;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic        chk_br;
    logic        taken;
    logic [31:0] target;
  } entry_t;

  logic        clk;
  logic        reset;
  logic        fs_to_ds_valid;
  fetch_bus_t  fs_to_ds;
  logic        ds_allowin;
  logic        es_allowin;
  logic        ds_to_es_valid;
  decode_bus_t ds_to_es;
  fwd_src_t    es_fwd;
  fwd_src_t    ms_fwd;
  rf_write_t   ws_wr;
  branch_bus_t br;

  entry_t      tbl [$];
  entry_t      cur;                  // entry being built
  logic        table_ready = 1'b0;
  logic [31:0] rng = 32'h93db_b0aa;
  int          checks = 0;
  int          value_errs = 0;
  int          other_errs = 0;

  tb_clock u_clk (.clk(clk));

  id_stage u_dut (
    .clk            (clk),
    .reset          (reset),
    .fs_to_ds_valid (fs_to_ds_valid),
    .fs_to_ds       (fs_to_ds),
    .ds_allowin     (ds_allowin),
    .es_allowin     (es_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es       (ds_to_es),
    .es_fwd         (es_fwd),
    .ms_fwd         (ms_fwd),
    .ws_wr          (ws_wr),
    .br             (br)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] next_random();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [31:0] r_inst(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sa);
    return {op_special, rs, rt, rd, sa, fn};
  endfunction

  function automatic logic [31:0] i_inst(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic fwd_src_t report(input logic load, input logic ready,
                                      input logic [4:0] dest, input logic [31:0] value);
    return {2'b11, load, ready, dest, value};  // valid, gr_we set
  endfunction

  // reference branch outcome, {taken, target}
  function automatic logic [32:0] branch_ref(input logic [31:0] inst, input logic [31:0] pc,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [31:0] pc4;
    logic [31:0] target;
    logic        taken;
    pc4    = pc + 32'd4;
    target = pc4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    taken  = 1'b0;
    case (inst[31:26])
      op_beq:    taken = (a == b);
      op_bne:    taken = (a != b);
      op_regimm: taken = inst[16] ? !a[31] : a[31];  // rt 1 is bgez
      op_blez:   taken = a[31] || a == 32'd0;
      op_bgtz:   taken = !a[31] && a != 32'd0;
      op_j, op_jal:
      begin
        taken  = 1'b1;
        target = {pc4[31:28], inst[25:0], 2'b00};
      end
      op_special:
      begin
        taken  = 1'b1;  // jr
        target = a;
      end
      default: taken = 1'b0;
    endcase
    return {taken, target};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      value_errs++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond)
    else
    begin
      other_errs++;
      $display("error at %0t: %s", $time, what);
    end
  endtask

  task automatic start_entry(input logic [31:0] inst);
    logic [31:0] r;
    r            = next_random();
    cur          = '0;
    cur.inst     = inst;
    cur.pc       = {r[31:2], 2'b00};  // word aligned
    cur.pre      = 1'b1;
    cur.pre_rs   = next_random();
    cur.pre_rt   = (inst[25:21] == inst[20:16]) ? cur.pre_rs : next_random();
    cur.rs_value = (inst[25:21] == 5'd0) ? 32'd0 : cur.pre_rs;  // r0 reads zero
    cur.rt_value = (inst[20:16] == 5'd0) ? 32'd0 : cur.pre_rt;
    cur.chk_ops  = 1'b1;
  endtask

  task automatic expect_dec(input logic [4:0] dest, input alu_op_t op, input src2_sel_t s2,
                            input logic gr_we, input logic mem_we);
    cur.chk_dec  = 1'b1;
    cur.dest     = dest;
    cur.alu_op   = op;
    cur.src2_sel = s2;
    cur.gr_we    = gr_we;
    cur.mem_we   = mem_we;
    tbl.push_back(cur);
  endtask

  task automatic expect_branch(input logic link);
    {cur.taken, cur.target} = branch_ref(cur.inst, cur.pc, cur.rs_value, cur.rt_value);
    cur.gr_we  = link;  // only jal writes a register
    cur.chk_br = 1'b1;
    tbl.push_back(cur);
  endtask

  task automatic build_table();
    logic [31:0] r;
    start_entry(r_inst(fn_addu, 5'd1, 5'd2, 5'd3, 5'd0));
    expect_dec(5'd3, alu_add, src2_reg, 1'b1, 1'b0);
    start_entry(r_inst(fn_sll, 5'd0, 5'd5, 5'd4, 5'd7));  // rs field is r0
    cur.src1_is_sa = 1'b1;  // shift by sa field
    expect_dec(5'd4, alu_sll, src2_reg, 1'b1, 1'b0);
    start_entry(i_inst(op_addiu, 5'd6, 5'd7, 16'h8001));
    expect_dec(5'd7, alu_add, src2_simm, 1'b1, 1'b0);
    start_entry(i_inst(op_ori, 5'd8, 5'd9, 16'hf00f));
    expect_dec(5'd9, alu_or, src2_zimm, 1'b1, 1'b0);
    start_entry(i_inst(op_lui, 5'd0, 5'd10, 16'h1234));
    expect_dec(5'd10, alu_lui, src2_simm, 1'b1, 1'b0);
    start_entry(i_inst(op_lw, 5'd11, 5'd12, 16'hfffc));
    cur.load_op = 1'b1;
    expect_dec(5'd12, alu_add, src2_simm, 1'b1, 1'b0);
    start_entry(i_inst(op_sw, 5'd13, 5'd14, 16'h2808));  // rd bits are 5
    expect_dec(5'd5, alu_add, src2_simm, 1'b0, 1'b1);
    start_entry(r_inst(fn_addu, 5'd16, 5'd17, 5'd15, 5'd0));  // all three report r16
    cur.es = report(1'b0, 1'b1, 5'd16, next_random());
    cur.ms = report(1'b0, 1'b1, 5'd16, next_random());
    cur.ws = {1'b1, 5'd16, next_random()};
    cur.rs_value = cur.es.result;
    expect_dec(5'd15, alu_add, src2_reg, 1'b1, 1'b0);
    start_entry(r_inst(fn_addu, 5'd16, 5'd17, 5'd15, 5'd0));  // memory beats write-back
    cur.ms = report(1'b0, 1'b1, 5'd16, next_random());
    cur.ws = {1'b1, 5'd16, next_random()};
    cur.rs_value = cur.ms.result;
    expect_dec(5'd15, alu_add, src2_reg, 1'b1, 1'b0);
    start_entry(r_inst(fn_subu, 5'd18, 5'd19, 5'd20, 5'd0));  // load in execute on rt
    cur.es    = report(1'b1, 1'b0, 5'd19, next_random());
    cur.stall = 4'd3;
    expect_dec(5'd20, alu_sub, src2_reg, 1'b1, 1'b0);
    start_entry(r_inst(fn_and, 5'd21, 5'd22, 5'd20, 5'd0));  // memory result not ready
    cur.ms    = report(1'b0, 1'b0, 5'd21, next_random());
    cur.stall = 4'd3;
    expect_dec(5'd20, alu_and, src2_reg, 1'b1, 1'b0);
    r = next_random();
    start_entry(i_inst(op_beq, 5'd23, 5'd23, r[15:0]));  // same register, always taken
    expect_branch(1'b0);
    r = next_random();
    start_entry(i_inst(op_beq, 5'd23, 5'd24, r[15:0]));
    cur.es    = report(1'b1, 1'b0, 5'd23, next_random());  // taken must wait
    cur.stall = 4'd2;
    expect_branch(1'b0);
    r = next_random();
    start_entry(i_inst(op_bne, 5'd25, 5'd26, r[15:0]));
    expect_branch(1'b0);
    r = next_random();
    start_entry(i_inst(op_regimm, 5'd27, rt_bgez, r[15:0]));
    expect_branch(1'b0);
    r = next_random();
    start_entry(i_inst(op_bgtz, 5'd28, 5'd0, r[15:0]));
    expect_branch(1'b0);
    r = next_random();
    start_entry(i_inst(op_blez, 5'd29, 5'd0, r[15:0]));
    expect_branch(1'b0);
    r = next_random();
    start_entry(i_inst(op_regimm, 5'd30, rt_bltz, r[15:0]));
    expect_branch(1'b0);
    r = next_random();
    start_entry({op_j, r[25:0]});
    expect_branch(1'b0);
    r = next_random();
    start_entry({op_jal, r[25:0]});
    cur.src1_is_pc = 1'b1;  // link address from pc
    expect_branch(1'b1);
    start_entry(r_inst(fn_jr, 5'd31, 5'd0, 5'd0, 5'd0));
    expect_branch(1'b0);
    start_entry(r_inst(fn_or, 5'd25, 5'd26, 5'd27, 5'd0));  // execute holds it off
    cur.hold = 4'd3;
    expect_dec(5'd27, alu_or, src2_reg, 1'b1, 1'b0);
    start_entry(i_inst(6'h3f, 5'd1, 5'd2, 16'h0000));  // unknown opcode
    cur.pre     = 1'b0;  // operands of no interest
    cur.chk_ops = 1'b0;
    cur.rsv     = 1'b1;
    tbl.push_back(cur);
  endtask

  task automatic run_entry(input entry_t t);
    decode_bus_t held;
    if (t.pre)
    begin
      @(posedge clk);
      ws_wr <= {1'b1, t.inst[rs_pos +: reg_addr_w], t.pre_rs};
      @(posedge clk);
      ws_wr <= {1'b1, t.inst[rt_pos +: reg_addr_w], t.pre_rt};
    end
    @(posedge clk);
    ws_wr          <= t.ws;
    es_fwd         <= t.es;
    ms_fwd         <= t.ms;
    es_allowin     <= (t.hold == 4'd0);
    fs_to_ds_valid <= 1'b1;
    fs_to_ds       <= {t.pc, t.inst};
    @(negedge clk);
    while (!ds_allowin) @(negedge clk);
    @(posedge clk);  // accepted here
    if (t.hold != 4'd0)
      fs_to_ds <= {t.pc + 32'd4, 32'd0};  // next inst offered during back-pressure
    else
      fs_to_ds_valid <= 1'b0;
    for (int n = 0; n < int'(t.stall); n++)
    begin
      @(negedge clk);
      check_val("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
      check_val("ds_allowin", 32'(ds_allowin), 32'd0);
      check_val("br.taken", 32'(br.taken), 32'd0);
    end
    if (t.stall != 4'd0)
    begin
      @(posedge clk);
      es_fwd <= '0;  // hazard gone
      ms_fwd <= '0;
    end
    @(negedge clk);
    while (!ds_to_es_valid) @(negedge clk);
    check_val("ds_to_es.pc", ds_to_es.pc, t.pc);
    check_val("ds_to_es.rsv", 32'(ds_to_es.rsv), 32'(t.rsv));
    check_val("ds_to_es.gr_we", 32'(ds_to_es.gr_we), 32'(t.gr_we));
    check_val("ds_to_es.mem_we", 32'(ds_to_es.mem_we), 32'(t.mem_we));
    check_val("ds_to_es.load_op", 32'(ds_to_es.load_op), 32'(t.load_op));
    check_val("ds_to_es.src1_is_sa", 32'(ds_to_es.src1_is_sa), 32'(t.src1_is_sa));
    check_val("ds_to_es.src1_is_pc", 32'(ds_to_es.src1_is_pc), 32'(t.src1_is_pc));
    check_val("ds_to_es.imm", 32'(ds_to_es.imm), 32'(t.inst[15:0]));  // low half of inst
    if (t.chk_dec)
    begin
      check_val("ds_to_es.dest", 32'(ds_to_es.dest), 32'(t.dest));
      check_val("ds_to_es.alu_op", 32'(ds_to_es.alu_op), 32'(t.alu_op));
      check_val("ds_to_es.src2_sel", 32'(ds_to_es.src2_sel), 32'(t.src2_sel));
    end
    if (t.chk_ops)
    begin
      check_val("ds_to_es.rs_value", ds_to_es.rs_value, t.rs_value);
      check_val("ds_to_es.rt_value", ds_to_es.rt_value, t.rt_value);
    end
    check_val("br.taken", 32'(br.taken), 32'(t.chk_br && t.taken));
    if (t.chk_br)
      check_val("br.target", br.target, t.target);
    held = ds_to_es;
    for (int n = 0; n < int'(t.hold); n++)
    begin
      if (n > 0)
      begin
        @(negedge clk);
        check_true(ds_to_es == held, "payload to execute changed while execute held it off");
      end
      check_val("ds_allowin", 32'(ds_allowin), 32'd0);  // next inst refused
      check_val("ds_to_es_valid", 32'(ds_to_es_valid), 32'd1);
    end
    if (t.hold != 4'd0)
    begin
      @(posedge clk);
      es_allowin     <= 1'b1;
      fs_to_ds_valid <= 1'b0;
      @(negedge clk);
    end
    while (!(ds_to_es_valid && es_allowin)) @(negedge clk);
    @(posedge clk);  // leaves to execute
    es_fwd <= '0;
    ms_fwd <= '0;
    ws_wr  <= '0;
    @(negedge clk);
    check_val("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);  // stage drained
  endtask

  initial
  begin
    reset          = 1'b1;
    fs_to_ds_valid = 1'b0;
    fs_to_ds       = '0;
    es_allowin     = 1'b1;
    es_fwd         = '0;
    ms_fwd         = '0;
    ws_wr          = '0;
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_val("ds_allowin", 32'(ds_allowin), 32'd1);  // empty after reset
    check_val("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
    check_val("br.taken", 32'(br.taken), 32'd0);
    foreach (tbl[i])
      run_entry(tbl[i]);
    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // watchdog, 20 cycles per table entry
  initial
  begin
    wait (table_ready);
    repeat (tbl.size() * 20) @(posedge clk);
    $display("watchdog expired, stimulus did not finish in %0d cycles", tbl.size() * 20);
    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errs, other_errs);
    $display("sim failed");
    $finish;
  end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;  // 100 ns period

endmodule

//--- id_stage.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/id_stage.sv
bench/tb_clock.sv
bench/id_stage_tb.sv

//--- logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import isa_pkg::*, pipe_pkg::*; (
  input  dec_ctrl_t       ctrl,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] inst,
  input  logic [xlen-1:0] rs_value,
  input  logic [xlen-1:0] rt_value,
  input  logic            fire,  // stage valid and ready_go
  output branch_bus_t     br
);

  br_kind_t        k;
  logic [xlen-1:0] pc_next;    // pc+4
  logic [xlen-1:0] br_offset;  // word offset in bytes
  logic            rs_eq_rt;
  logic            rs_neg;
  logic            rs_lez;
  logic            cond;

  assign k         = ctrl.br_kind;
  assign pc_next   = pc + xlen'(4);
  assign br_offset = {{(xlen-imm_w-2){inst[imm_w-1]}}, inst[imm_w-1:0], 2'b00};

  assign rs_eq_rt = (rs_value == rt_value);
  assign rs_neg   = rs_value[xlen-1];
  assign rs_lez   = rs_neg || rs_value == '0;

  assign cond = (k.beq  &&  rs_eq_rt) ||
                (k.bne  && !rs_eq_rt) ||
                (k.bgez && !rs_neg)   ||
                (k.bltz &&  rs_neg)   ||
                (k.blez &&  rs_lez)   ||
                (k.bgtz && !rs_lez)   ||
                k.j || k.jr;  // jumps unconditional

  assign br.taken = fire && cond;

  always_comb
  begin
    if (k.jr)
      br.target = rs_value;
    else if (k.j)
      br.target = {pc_next[xlen-1 -: 4], inst[jidx_w-1:0], 2'b00};  // 256 MB region
    else
      br.target = pc_next + br_offset;
  end

endmodule

//--- logic/id_stage.sv
`timescale 1ns/1ps

module id_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        fs_to_ds_valid,
  input  fetch_bus_t  fs_to_ds,
  output logic        ds_allowin,
  input  logic        es_allowin,
  output logic        ds_to_es_valid,
  output decode_bus_t ds_to_es,
  input  fwd_src_t    es_fwd,
  input  fwd_src_t    ms_fwd,
  input  rf_write_t   ws_wr,
  output branch_bus_t br
);

  logic                  ds_valid;
  fetch_bus_t            ds_bus;    // held instruction and pc
  logic                  ready_go;
  decode_bus_t           dec_fields;
  dec_ctrl_t             dec_ctrl;
  logic [reg_addr_w-1:0] rs;
  logic [reg_addr_w-1:0] rt;
  logic [xlen-1:0]       rf_rdata1;
  logic [xlen-1:0]       rf_rdata2;
  logic [xlen-1:0]       rs_value;
  logic [xlen-1:0]       rt_value;

  assign rs = ds_bus.inst[rs_pos +: reg_addr_w];
  assign rt = ds_bus.inst[rt_pos +: reg_addr_w];

  assign ds_allowin     = !ds_valid || (ready_go && es_allowin);  // empty or leaving
  assign ds_to_es_valid = ds_valid && ready_go;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ds_valid <= 1'b0;
    end
    else if (ds_allowin)
    begin
      ds_valid <= fs_to_ds_valid;  // drains to empty when fetch has nothing
    end
  end

  always_ff @(posedge clk)
  begin
    if (fs_to_ds_valid && ds_allowin)
    begin
      ds_bus <= fs_to_ds;
    end
  end

  inst_decoder u_dec (
    .inst   (ds_bus.inst),
    .fields (dec_fields),
    .ctrl   (dec_ctrl)
  );

  reg_file u_rf (
    .clk    (clk),
    .raddr1 (rs),
    .raddr2 (rt),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .wr     (ws_wr)
  );

  operand_bypass u_byp (
    .rs        (rs),
    .rt        (rt),
    .uses_rs   (dec_ctrl.uses_rs),
    .uses_rt   (dec_ctrl.uses_rt),
    .rf_rdata1 (rf_rdata1),
    .rf_rdata2 (rf_rdata2),
    .es_fwd    (es_fwd),
    .ms_fwd    (ms_fwd),
    .ws_wr     (ws_wr),
    .rs_value  (rs_value),
    .rt_value  (rt_value),
    .ready_go  (ready_go)
  );

  branch_unit u_br (
    .ctrl     (dec_ctrl),
    .pc       (ds_bus.pc),
    .inst     (ds_bus.inst),
    .rs_value (rs_value),
    .rt_value (rt_value),
    .fire     (ds_to_es_valid),  // no redirect while stalled
    .br       (br)
  );

  always_comb
  begin
    ds_to_es          = dec_fields;
    ds_to_es.rs_value = rs_value;  // forwarded operands
    ds_to_es.rt_value = rt_value;
    ds_to_es.pc       = ds_bus.pc;
  end

  // execute back-pressure must not disturb the offered payload
  assert property (@(posedge clk) disable iff (reset)
                   ds_to_es_valid && !es_allowin |=> $stable(ds_to_es))
  else $error("id_stage: ds_to_es changed under back-pressure");

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import isa_pkg::*, pipe_pkg::*; (
  input  logic [xlen-1:0] inst,
  output decode_bus_t     fields,
  output dec_ctrl_t       ctrl
);

  logic [op_w-1:0]       op;
  logic [fn_w-1:0]       func;
  logic [reg_addr_w-1:0] rs;
  logic [reg_addr_w-1:0] rt;
  logic [reg_addr_w-1:0] rd;
  logic [reg_addr_w-1:0] sa;
  logic                  special;
  logic                  r_alu;    // three-register alu, variable shifts
  logic                  r_shift;  // shift by sa field
  logic                  i_sext;   // arithmetic immediates
  logic                  i_zext;   // logical immediates
  logic                  is_lui;
  logic                  is_lw;
  logic                  is_sw;
  logic                  is_jal;
  logic                  is_jr;
  logic                  is_jalr;
  logic                  legal;
  br_kind_t              kind;
  alu_op_t               alu_op;

  assign op   = inst[op_pos +: op_w];
  assign rs   = inst[rs_pos +: reg_addr_w];
  assign rt   = inst[rt_pos +: reg_addr_w];
  assign rd   = inst[rd_pos +: reg_addr_w];
  assign sa   = inst[sa_pos +: reg_addr_w];
  assign func = inst[fn_w-1:0];

  assign special = (op == op_special);
  assign r_alu   = special && sa == '0 &&
                   func inside {fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu,
                                fn_and, fn_or, fn_xor, fn_nor, fn_sllv, fn_srlv, fn_srav};
  assign r_shift = special && rs == '0 && func inside {fn_sll, fn_srl, fn_sra};
  assign is_jr   = special && func == fn_jr && rt == '0 && rd == '0 && sa == '0;
  assign is_jalr = special && func == fn_jalr && rt == '0 && sa == '0;
  assign i_sext  = op inside {op_addi, op_addiu, op_slti, op_sltiu};
  assign i_zext  = op inside {op_andi, op_ori, op_xori};
  assign is_lui  = (op == op_lui) && rs == '0;
  assign is_lw   = (op == op_lw);
  assign is_sw   = (op == op_sw);
  assign is_jal  = (op == op_jal);

  assign kind.beq  = (op == op_beq);
  assign kind.bne  = (op == op_bne);
  assign kind.bgez = (op == op_regimm) && rt == rt_bgez;
  assign kind.bltz = (op == op_regimm) && rt == rt_bltz;
  assign kind.blez = (op == op_blez) && rt == '0;
  assign kind.bgtz = (op == op_bgtz) && rt == '0;
  assign kind.j    = (op == op_j) || is_jal;
  assign kind.jr   = is_jr || is_jalr;

  // anything not matched above is reserved
  assign legal = r_alu || r_shift || i_sext || i_zext || is_lui || is_lw || is_sw || (|kind);

  always_comb
  begin
    alu_op = alu_add;  // add forms, lw/sw address, link pc+8
    if (r_alu || r_shift)
    begin
      case (func)
        fn_sub, fn_subu: alu_op = alu_sub;
        fn_slt:          alu_op = alu_slt;
        fn_sltu:         alu_op = alu_sltu;
        fn_and:          alu_op = alu_and;
        fn_or:           alu_op = alu_or;
        fn_xor:          alu_op = alu_xor;
        fn_nor:          alu_op = alu_nor;
        fn_sll, fn_sllv: alu_op = alu_sll;
        fn_srl, fn_srlv: alu_op = alu_srl;
        fn_sra, fn_srav: alu_op = alu_sra;
        default:         alu_op = alu_add;
      endcase
    end
    else
    begin
      case (op)
        op_slti:  alu_op = alu_slt;
        op_sltiu: alu_op = alu_sltu;
        op_andi:  alu_op = alu_and;
        op_ori:   alu_op = alu_or;
        op_xori:  alu_op = alu_xor;
        op_lui:   alu_op = alu_lui;
        default:  alu_op = alu_add;
      endcase
    end
  end

  assign ctrl.br_kind = kind;
  assign ctrl.link    = is_jal || is_jalr;
  assign ctrl.uses_rs = r_alu || i_sext || i_zext || is_lw || is_sw || kind.beq || kind.bne ||
                        kind.bgez || kind.bltz || kind.blez || kind.bgtz || kind.jr;
  assign ctrl.uses_rt = r_alu || r_shift || is_sw || kind.beq || kind.bne;  // sw stores rt

  always_comb
  begin
    fields            = '0;  // operands and pc filled at top level
    fields.alu_op     = alu_op;
    fields.src1_is_sa = r_shift;
    fields.src1_is_pc = ctrl.link;
    if (ctrl.link)
      fields.src2_sel = src2_eight;
    else if (i_sext || is_lui || is_lw || is_sw)
      fields.src2_sel = src2_simm;  // lui shifts imm in the alu, extension irrelevant
    else if (i_zext)
      fields.src2_sel = src2_zimm;
    else
      fields.src2_sel = src2_reg;
    fields.load_op = is_lw;
    fields.mem_we  = is_sw;  // zero for reserved by construction
    fields.gr_we   = r_alu || r_shift || i_sext || i_zext || is_lui || is_lw || ctrl.link;
    fields.rsv     = !legal;
    if (is_jal)
      fields.dest = 5'd31;
    else if (i_sext || i_zext || is_lui || is_lw)
      fields.dest = rt;
    else
      fields.dest = rd;  // jalr links to rd
    fields.imm = inst[imm_w-1:0];
  end

endmodule

//--- logic/isa_pkg.sv
package isa_pkg;

  localparam int xlen       = 32;  // data path width
  localparam int reg_addr_w = 5;   // gpr index, also sa width
  localparam int num_regs   = 32;  // r0 hardwired zero

  // instruction word layout
  localparam int op_pos = 26;
  localparam int rs_pos = 21;
  localparam int rt_pos = 16;
  localparam int rd_pos = 11;
  localparam int sa_pos = 6;
  localparam int op_w   = 6;
  localparam int fn_w   = 6;   // func sits at bit 0
  localparam int imm_w  = 16;
  localparam int jidx_w = 26;  // j/jal index

  localparam logic [op_w-1:0] op_special = 6'h00;  // r-type, decoded by func
  localparam logic [op_w-1:0] op_regimm  = 6'h01;  // bgez/bltz via rt
  localparam logic [op_w-1:0] op_j       = 6'h02;
  localparam logic [op_w-1:0] op_jal     = 6'h03;
  localparam logic [op_w-1:0] op_beq     = 6'h04;
  localparam logic [op_w-1:0] op_bne     = 6'h05;
  localparam logic [op_w-1:0] op_blez    = 6'h06;
  localparam logic [op_w-1:0] op_bgtz    = 6'h07;
  localparam logic [op_w-1:0] op_addi    = 6'h08;
  localparam logic [op_w-1:0] op_addiu   = 6'h09;
  localparam logic [op_w-1:0] op_slti    = 6'h0a;
  localparam logic [op_w-1:0] op_sltiu   = 6'h0b;
  localparam logic [op_w-1:0] op_andi    = 6'h0c;
  localparam logic [op_w-1:0] op_ori     = 6'h0d;
  localparam logic [op_w-1:0] op_xori    = 6'h0e;
  localparam logic [op_w-1:0] op_lui     = 6'h0f;
  localparam logic [op_w-1:0] op_lw      = 6'h23;
  localparam logic [op_w-1:0] op_sw      = 6'h2b;

  localparam logic [fn_w-1:0] fn_sll  = 6'h00;
  localparam logic [fn_w-1:0] fn_srl  = 6'h02;
  localparam logic [fn_w-1:0] fn_sra  = 6'h03;
  localparam logic [fn_w-1:0] fn_sllv = 6'h04;
  localparam logic [fn_w-1:0] fn_srlv = 6'h06;
  localparam logic [fn_w-1:0] fn_srav = 6'h07;
  localparam logic [fn_w-1:0] fn_jr   = 6'h08;
  localparam logic [fn_w-1:0] fn_jalr = 6'h09;
  localparam logic [fn_w-1:0] fn_add  = 6'h20;  // no overflow trap here
  localparam logic [fn_w-1:0] fn_addu = 6'h21;
  localparam logic [fn_w-1:0] fn_sub  = 6'h22;
  localparam logic [fn_w-1:0] fn_subu = 6'h23;
  localparam logic [fn_w-1:0] fn_and  = 6'h24;
  localparam logic [fn_w-1:0] fn_or   = 6'h25;
  localparam logic [fn_w-1:0] fn_xor  = 6'h26;
  localparam logic [fn_w-1:0] fn_nor  = 6'h27;
  localparam logic [fn_w-1:0] fn_slt  = 6'h2a;
  localparam logic [fn_w-1:0] fn_sltu = 6'h2b;

  localparam logic [reg_addr_w-1:0] rt_bltz = 5'd0;  // regimm rt codes
  localparam logic [reg_addr_w-1:0] rt_bgez = 5'd1;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
    alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
  } alu_op_t;

  typedef enum logic [1:0] {
    src2_reg,   // rt value
    src2_simm,  // sign-extended imm
    src2_zimm,  // zero-extended imm
    src2_eight  // link address pc+8
  } src2_sel_t;

endpackage

//--- logic/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import isa_pkg::*, pipe_pkg::*; (
  input  logic [reg_addr_w-1:0] rs,
  input  logic [reg_addr_w-1:0] rt,
  input  logic                  uses_rs,
  input  logic                  uses_rt,
  input  logic [xlen-1:0]       rf_rdata1,
  input  logic [xlen-1:0]       rf_rdata2,
  input  fwd_src_t              es_fwd,
  input  fwd_src_t              ms_fwd,
  input  rf_write_t             ws_wr,
  output logic [xlen-1:0]       rs_value,
  output logic [xlen-1:0]       rt_value,
  output logic                  ready_go
);

  logic [reg_addr_w-1:0] src    [2];  // 0 = rs, 1 = rt
  logic [xlen-1:0]       rf_val [2];
  logic [xlen-1:0]       value  [2];
  logic [1:0]            uses;
  logic [1:0]            stall;

  assign src[0]    = rs;
  assign src[1]    = rt;
  assign rf_val[0] = rf_rdata1;
  assign rf_val[1] = rf_rdata2;
  assign uses      = {uses_rt, uses_rs};

  for (genvar i = 0; i < 2; i++)
  begin : g_src
    logic live;  // r0 never matches
    logic es_hit;
    logic ms_hit;
    logic ws_hit;

    assign live   = (src[i] != '0);
    assign es_hit = live && es_fwd.valid && es_fwd.gr_we && es_fwd.dest == src[i];
    assign ms_hit = live && ms_fwd.valid && ms_fwd.gr_we && ms_fwd.dest == src[i];
    assign ws_hit = live && ws_wr.we && ws_wr.waddr == src[i];

    // youngest producer wins
    assign value[i] = es_hit ? es_fwd.result :
                      ms_hit ? ms_fwd.result :
                      ws_hit ? ws_wr.wdata   : rf_val[i];

    // mem readiness only matters when execute does not shadow it
    assign stall[i] = uses[i] && ((es_hit && es_fwd.is_load) ||
                                  (!es_hit && ms_hit && !ms_fwd.result_ready));
  end

  assign rs_value = value[0];
  assign rt_value = value[1];
  assign ready_go = ~|stall;  // unused sources never block

endmodule

//--- logic/pipe_pkg.sv
package pipe_pkg;

  import isa_pkg::*;

  // fetch -> decode
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } fetch_bus_t;

  // decode -> execute, 129 bits
  typedef struct packed {
    alu_op_t               alu_op;
    logic                  src1_is_sa;  // shift amount from sa field
    logic                  src1_is_pc;  // link forms
    src2_sel_t             src2_sel;
    logic                  load_op;
    logic                  mem_we;
    logic                  gr_we;
    logic                  rsv;         // reserved instruction
    logic [reg_addr_w-1:0] dest;
    logic [imm_w-1:0]      imm;
    logic [xlen-1:0]       rs_value;
    logic [xlen-1:0]       rt_value;
    logic [xlen-1:0]       pc;
  } decode_bus_t;

  // later stage reporting back for bypass and hazard check
  typedef struct packed {
    logic                  valid;
    logic                  gr_we;
    logic                  is_load;       // result not known before mem
    logic                  result_ready;  // result field usable now
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       result;
  } fwd_src_t;

  // write-back port of the gpr file
  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
  } rf_write_t;

  // decode -> fetch redirect
  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } branch_bus_t;

  // one-hot, all zero for non-branches
  typedef struct packed {
    logic beq;
    logic bne;
    logic bgez;
    logic bgtz;
    logic blez;
    logic bltz;
    logic j;    // j and jal
    logic jr;   // jr and jalr
  } br_kind_t;

  typedef struct packed {
    br_kind_t br_kind;
    logic     link;     // jal/jalr write the return address
    logic     uses_rs;
    logic     uses_rt;
  } dec_ctrl_t;

endpackage

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import isa_pkg::*, pipe_pkg::*; (
  input  logic                  clk,
  input  logic [reg_addr_w-1:0] raddr1,
  input  logic [reg_addr_w-1:0] raddr2,
  output logic [xlen-1:0]       rdata1,
  output logic [xlen-1:0]       rdata2,
  input  rf_write_t             wr
);

  logic [xlen-1:0] regs [num_regs];  // entry 0 never written

  always_ff @(posedge clk)
  begin
    if (wr.we && wr.waddr != '0)
    begin
      regs[wr.waddr] <= wr.wdata;
    end
  end

  // async read, same-cycle write covered by the bypass
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the decode stage testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module id_stage_tb -f id_stage.f -o id_stage_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/id_stage_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "sim failed" "$log"; then
  exit 1
fi

exit 0
